// File: all.f
src/fetch_pkg.sv
src/axi_pkg.sv
src/icache_array.sv
src/burst_reader.sv
src/fetch_control.sv
src/inst_rom.sv
src/fetch_top.sv
dv/fetch_checker.sv
dv/fetch_tb.sv

// File: dv/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker
  import fetch_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  inst_valid,
  input  inst_t inst,
  input  addr_t inst_pc,
  input  logic  fetch_busy,
  input  logic  idu_ready,
  input  logic  block,
  input  logic  clear_pipeline,
  input  logic  clear_cache,
  input  addr_t npc,
  input  logic  test_end,
  input  int    test_num,
  output int    error_count,
  output int    word_count,
  output int    fill_count
);

  localparam addr_t boot_pc = 32'h3000_0000;

  inst_t rom [rom_words];
  logic [25:0] model_tag [4];  // Address bits 31:6 of each resident line.
  logic [3:0] model_valid;

  addr_t expect_pc;
  logic prev_valid;
  logic prev_accept;
  logic prev_busy;

  int errors = 0;
  int words = 0;
  int fills = 0;
  int test_words = 0;
  int test_fills = 0;
  int test_misses = 0;
  int test_errors = 0;

  assign error_count = errors;
  assign word_count = words;
  assign fill_count = fills;

  initial begin
    $readmemh("rom.hex", rom);
  end

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
    errors++;
    test_errors++;
    $display("FAIL %0t: %s is %h, expected %h", $time, what, got, want);
  endtask

  // A word entering the output register shows which line was read.
  task automatic note_line(input addr_t pc);
    int slot;
    slot = int'(pc[5:4]);
    if (!model_valid[slot] || model_tag[slot] != pc[31:6]) begin
      model_valid[slot] = 1'b1;
      model_tag[slot] = pc[31:6];
      test_misses++;  // Not resident, so a fill had to bring it in.
    end
  endtask

  task automatic check_word();
    words++;
    test_words++;
    if (inst_pc !== expect_pc) begin
      report_mismatch("inst_pc", inst_pc, expect_pc);
    end
    if (inst !== rom[inst_pc[6:2]]) begin
      report_mismatch($sformatf("inst at %h", inst_pc), inst, rom[inst_pc[6:2]]);
    end
    expect_pc = inst_pc + 32'd4;
  endtask

  task automatic finish_test();
    if (test_fills != test_misses) begin
      errors++;
      test_errors++;
      $display("FAIL %0t: test %0d made %0d line fills, expected %0d",
               $time, test_num, test_fills, test_misses);
    end
    $display("test %0d: %0d words, %0d fills, %0d errors",
             test_num, test_words, test_fills, test_errors);
    test_words = 0;
    test_fills = 0;
    test_misses = 0;
    test_errors = 0;
  endtask

  always @(posedge clock) begin
    if (reset) begin
      expect_pc = boot_pc;
      model_valid = '0;
      prev_valid = 1'b0;
      prev_accept = 1'b0;
      prev_busy = 1'b0;
    end else begin
      if (inst_valid && (!prev_valid || prev_accept)) begin
        note_line(inst_pc);
      end
      if (fetch_busy && !prev_busy) begin
        fills++;
        test_fills++;
      end
      if (clear_pipeline) begin
        expect_pc = npc;  // The word held from the old path is dropped.
      end else if (inst_valid && idu_ready && !block) begin
        check_word();
      end
      if (clear_cache) begin
        model_valid = '0;
      end
      if (test_end) begin
        finish_test();
      end
      prev_valid = inst_valid;
      prev_accept = idu_ready && !block;
      prev_busy = fetch_busy;
    end
  end

endmodule

// File: dv/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb
  import fetch_pkg::*;
();

  localparam int num_tests = 10;
  localparam int margin_cycles = 200;

  // Rows end in the middle of a line, so the word fetched ahead is always resident.
  int    run_len      [num_tests] = '{150, 100, 250, 400, 250, 120, 300, 250, 150, 200};
  int    random_ready [num_tests] = '{0, 0, 0, 1, 1, 0, 1, 0, 0, 1};
  int    block_bursts [num_tests] = '{0, 0, 0, 1, 0, 0, 1, 0, 0, 0};
  int    redirect     [num_tests] = '{0, 1, 0, 0, 0, 1, 1, 0, 1, 1};
  int    flush        [num_tests] = '{0, 0, 0, 0, 0, 0, 0, 1, 1, 0};
  int    words        [num_tests] = '{14, 15, 31, 40, 20, 9, 25, 20, 14, 14};
  addr_t target       [num_tests] = '{32'h0, 32'h3000_0000, 32'h0, 32'h0, 32'h0,
                                      32'h3000_0108, 32'h3000_0044, 32'h0,
                                      32'h3000_0000, 32'h3000_0000};

  logic  clock;
  logic  reset;
  addr_t npc;
  logic  clear_pipeline;
  logic  clear_cache;
  logic  idu_ready;
  logic  block;
  logic  inst_valid;
  inst_t inst;
  addr_t inst_pc;
  logic  fetch_busy;

  logic test_end;
  int   test_num;
  int   check_errors;
  int   check_words;
  int   check_fills;

  int seed = 80408;
  int block_left = 0;
  int budget_errors = 0;

  fetch_top dut (
    .clock          (clock),
    .reset          (reset),
    .npc            (npc),
    .clear_pipeline (clear_pipeline),
    .clear_cache    (clear_cache),
    .idu_ready      (idu_ready),
    .block          (block),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .inst_pc        (inst_pc),
    .fetch_busy     (fetch_busy)
  );

  fetch_checker check_unit (
    .clock          (clock),
    .reset          (reset),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .inst_pc        (inst_pc),
    .fetch_busy     (fetch_busy),
    .idu_ready      (idu_ready),
    .block          (block),
    .clear_pipeline (clear_pipeline),
    .clear_cache    (clear_cache),
    .npc            (npc),
    .test_end       (test_end),
    .test_num       (test_num),
    .error_count    (check_errors),
    .word_count     (check_words),
    .fill_count     (check_fills)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic drive_decode(input int row);
    if (random_ready[row] != 0) begin
      idu_ready <= (($random(seed) & 3) != 0);  // Ready three cycles in four.
    end else begin
      idu_ready <= 1'b1;
    end
    if (block_bursts[row] == 0) begin
      block <= 1'b0;
    end else if (block_left > 0) begin
      block <= 1'b1;
      block_left--;
    end else if (($random(seed) & 7) == 0) begin
      block <= 1'b1;
      block_left = $random(seed) & 3;
    end else begin
      block <= 1'b0;
    end
  endtask

  task automatic run_test(input int row);
    int accepted;
    int cycles;
    accepted = 0;
    cycles = 0;
    if (redirect[row] != 0 || flush[row] != 0) begin
      clear_pipeline <= (redirect[row] != 0);
      clear_cache <= (flush[row] != 0);
      npc <= target[row];
      @(posedge clock);
      clear_pipeline <= 1'b0;
      clear_cache <= 1'b0;
    end
    while (accepted < words[row] && cycles < run_len[row]) begin
      drive_decode(row);
      @(posedge clock);
      cycles++;
      if (inst_valid && idu_ready && !block) begin
        accepted++;
      end
    end
    idu_ready <= 1'b0;  // Stall decode between rows.
    block <= 1'b0;
    block_left = 0;
    if (accepted < words[row]) begin
      budget_errors++;
      $display("test %0d got only %0d of %0d words before its %0d cycles ran out",
               row, accepted, words[row], run_len[row]);
    end
    repeat (3) @(posedge clock);
    test_num <= row;
    test_end <= 1'b1;
    @(posedge clock);
    test_end <= 1'b0;
  endtask

  initial begin
    reset = 1'b1;
    npc = '0;
    clear_pipeline = 1'b0;
    clear_cache = 1'b0;
    idu_ready = 1'b0;
    block = 1'b0;
    test_end = 1'b0;
    test_num = 0;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    for (int row = 0; row < num_tests; row++) begin
      run_test(row);
    end
    repeat (2) @(posedge clock);
    $display("summary: %0d tests, %0d words, %0d fills, %0d errors",
             num_tests, check_words, check_fills, check_errors + budget_errors);
    if (check_errors == 0 && budget_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    int limit;
    limit = 16 + margin_cycles;
    for (int row = 0; row < num_tests; row++) begin
      limit += run_len[row] + 8;  // Redirect, settle and report cycles.
    end
    #(limit * 10);
    $display("timeout: the run was still going after %0d cycles", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: rom.hex
// One 32-bit instruction word per line, ROM word 0 first.
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00a00513
00b00593
00c00613
00d00693
00e00713
00f00793
01000813
01100893
01200913
01300993
01400a13
01500a93
01600b13
01700b93
01800c13
01900c93
01a00d13
01b00d93
01c00e13
01d00e93
01e00f13
01f00f93
0000006f

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module fetch_tb -f all.f
output=$(./obj_dir/Vfetch_tb 2>&1) || true
echo "$output"
echo "$output" | grep -q "ALL TESTS PASSED"

// File: src/axi_pkg.sv
package axi_pkg;

  typedef logic [7:0] burst_len_t;  // Beats minus one.

  // One cache line per burst.
  localparam burst_len_t line_burst_len = 8'd3;

  // Cycles between address acceptance and the first read beat.
  localparam int rom_latency = 2;

  typedef enum logic [1:0] {
    idle,
    address,
    data
  } burst_state_t;

endpackage

// File: src/burst_reader.sv
`timescale 1ns/1ps

module burst_reader
  import fetch_pkg::*, axi_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       fill_start,
  input  addr_t      fill_addr,
  output addr_t      araddr,
  output burst_len_t arlen,
  output logic       arvalid,
  input  logic       arready,
  output logic       rready,
  input  inst_t      rdata,
  input  logic       rvalid,
  input  logic       rlast,
  output logic       beat_valid,
  output inst_t      beat_data,
  output logic       fill_done
);

  burst_state_t state;

  assign arlen = line_burst_len;
  assign arvalid = (state == address);
  assign rready = (state == data);

  assign beat_valid = rready && rvalid;
  assign beat_data = rdata;
  assign fill_done = beat_valid && rlast;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle:    if (fill_start) state <= address;
        address: if (arready) state <= data;
        data:    if (fill_done) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (fill_start) begin
      araddr <= fill_addr;
    end
  end

  // Memory must not return data for a burst that was never requested.
  assert property (@(posedge clock) disable iff (reset)
    (state == idle) |-> !rvalid)
    else $error("burst_reader: rvalid while idle");

endmodule

// File: src/fetch_control.sv
`timescale 1ns/1ps

module fetch_control
  import fetch_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  addr_t npc,
  input  logic  clear_pipeline,
  input  logic  idu_ready,
  input  logic  block,
  input  logic  hit,
  input  logic  fill_done,
  input  inst_t hit_word,
  output addr_t lookup_addr,
  output logic  fill_start,
  output addr_t fill_addr,
  output logic  inst_valid,
  output inst_t inst,
  output addr_t inst_pc,
  output logic  fetch_busy
);

  fetch_state_t state;
  addr_t pc;
  addr_t fill_line;  // Line being filled, held so a redirect cannot move it.
  logic accept;
  logic deliver;

  assign accept = idu_ready && !block;
  assign deliver = !clear_pipeline && (state == lookup) && accept && hit;

  assign fill_addr = {pc[31:4], 4'b0000};
  assign fill_start = !clear_pipeline && (state == lookup) && accept && !hit;

  // During a fill the cache must keep pointing at the line in flight.
  assign lookup_addr = (state == refill) ? fill_line : pc;
  assign fetch_busy = (state == refill);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= lookup;
      pc <= reset_pc;
      inst_valid <= 1'b0;
    end else begin
      if (clear_pipeline) begin
        pc <= npc;           // Redirect beats everything.
        inst_valid <= 1'b0;
      end else if (deliver) begin
        pc <= pc + 32'd4;
        inst_valid <= 1'b1;
      end else if (fill_start) begin
        inst_valid <= 1'b0;
      end

      case (state)
        lookup:  if (fill_start) state <= refill;
        refill:  if (fill_done) state <= lookup;
        default: state <= lookup;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (deliver) begin
      inst <= hit_word;
      inst_pc <= pc;
    end
    if (fill_start) begin
      fill_line <= fill_addr;
    end
  end

  // Only one line fill may be outstanding, so a fill completes only in refill.
  assert property (@(posedge clock) disable iff (reset)
    fill_done |-> (state == refill))
    else $error("fetch_control: fill_done outside refill");

endmodule

// File: src/fetch_pkg.sv
package fetch_pkg;

  // Address and data widths.
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [127:0] line_t;  // Four words, lowest word in bits 31:0.

  // Fields of a fetch address.
  typedef logic [25:0] tag_t;       // Bits 31:6.
  typedef logic [1:0] index_t;      // Bits 5:4.
  typedef logic [1:0] word_sel_t;   // Bits 3:2.

  // Direct-mapped cache of four 16-byte lines.
  localparam int cache_sets = 4;

  localparam addr_t reset_pc = 32'h3000_0000;

  // Boot ROM size in words, aliased over the whole address space.
  localparam int rom_words = 32;

  typedef enum logic {
    lookup,
    refill
  } fetch_state_t;

endpackage

// File: src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
  import fetch_pkg::*, axi_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  addr_t npc,
  input  logic  clear_pipeline,
  input  logic  clear_cache,
  input  logic  idu_ready,
  input  logic  block,
  output logic  inst_valid,
  output inst_t inst,
  output addr_t inst_pc,
  output logic  fetch_busy
);

  addr_t lookup_addr;
  addr_t fill_addr;
  logic hit;
  inst_t hit_word;
  logic fill_start;
  logic fill_done;
  logic beat_valid;
  inst_t beat_data;

  // Read channels between the reader and the boot ROM.
  addr_t araddr;
  burst_len_t arlen;
  logic arvalid;
  logic arready;
  logic rready;
  inst_t rdata;
  logic rvalid;
  logic rlast;

  fetch_control u_control (
    .clock          (clock),
    .reset          (reset),
    .npc            (npc),
    .clear_pipeline (clear_pipeline),
    .idu_ready      (idu_ready),
    .block          (block),
    .hit            (hit),
    .fill_done      (fill_done),
    .hit_word       (hit_word),
    .lookup_addr    (lookup_addr),
    .fill_start     (fill_start),
    .fill_addr      (fill_addr),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .inst_pc        (inst_pc),
    .fetch_busy     (fetch_busy)
  );

  icache_array u_cache (
    .clock       (clock),
    .reset       (reset),
    .flush       (clear_cache),
    .lookup_addr (lookup_addr),
    .beat_valid  (beat_valid),
    .beat_data   (beat_data),
    .fill_done   (fill_done),
    .hit         (hit),
    .hit_word    (hit_word)
  );

  burst_reader u_reader (
    .clock      (clock),
    .reset      (reset),
    .fill_start (fill_start),
    .fill_addr  (fill_addr),
    .araddr     (araddr),
    .arlen      (arlen),
    .arvalid    (arvalid),
    .arready    (arready),
    .rready     (rready),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .rlast      (rlast),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .fill_done  (fill_done)
  );

  inst_rom u_rom (
    .clock   (clock),
    .reset   (reset),
    .araddr  (araddr),
    .arlen   (arlen),
    .arvalid (arvalid),
    .arready (arready),
    .rready  (rready),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .rlast   (rlast)
  );

endmodule

// File: src/icache_array.sv
`timescale 1ns/1ps

module icache_array
  import fetch_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  flush,
  input  addr_t lookup_addr,
  input  logic  beat_valid,
  input  inst_t beat_data,
  input  logic  fill_done,
  output logic  hit,
  output inst_t hit_word
);

  logic [cache_sets-1:0] valid;
  tag_t tags [cache_sets];
  line_t lines [cache_sets];

  tag_t tag;
  index_t index;
  word_sel_t word_sel;
  line_t cur_line;

  assign tag = lookup_addr[31:6];
  assign index = lookup_addr[5:4];
  assign word_sel = lookup_addr[3:2];
  assign cur_line = lines[index];

  assign hit = valid[index] && (tags[index] == tag);
  assign hit_word = cur_line[word_sel*32 +: 32];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else if (flush) begin
      valid <= '0;  // Flush wins over a completing fill.
    end else if (fill_done) begin
      valid[index] <= 1'b1;
    end
  end

  // Beats arrive lowest word first, so shift in from the top.
  always_ff @(posedge clock) begin
    if (beat_valid) begin
      lines[index] <= {beat_data, cur_line[127:32]};
    end
    if (fill_done) begin
      tags[index] <= tag;
    end
  end

endmodule

// File: src/inst_rom.sv
`timescale 1ns/1ps

module inst_rom
  import fetch_pkg::*, axi_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  addr_t      araddr,
  input  burst_len_t arlen,
  input  logic       arvalid,
  output logic       arready,
  input  logic       rready,
  output inst_t      rdata,
  output logic       rvalid,
  output logic       rlast
);

  inst_t mem [rom_words];

  burst_state_t state;
  addr_t addr_q;
  burst_len_t beats_left;
  logic [3:0] wait_cnt;

  initial begin
    $readmemh("rom.hex", mem);
  end

  assign arready = (state == idle);
  assign rvalid = (state == data);
  assign rlast = rvalid && (beats_left == '0);
  assign rdata = mem[addr_q[6:2]];  // Every address aliases onto the 32 words.

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (arvalid) begin
            state <= address;
          end
        end
        address: begin
          if (wait_cnt == '0) begin
            state <= data;
          end
        end
        data: begin
          if (rready && rlast) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (arvalid && arready) begin
      addr_q <= araddr;
      beats_left <= arlen;
      wait_cnt <= 4'(rom_latency - 1);
    end else if (state == address) begin
      wait_cnt <= wait_cnt - 4'd1;
    end else if (rvalid && rready) begin
      addr_q <= addr_q + 32'd4;  // Next word, lowest first.
      beats_left <= beats_left - 8'd1;
    end
  end

endmodule
